// ==== bench/mul_unit_asserts.sv ====
`timescale 1ns/1ps

module mul_unit_asserts (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic req_ready,
	input logic resp_valid,
	input logic resp_ready,
	input mul_pkg::mul_resp_t resp
);

	int failures = 0; // read by the testbench at the end of the run.

	// a response waiting on the consumer keeps its value until it is taken.
	property resp_held;
		@(posedge clk) disable iff (reset)
		resp_valid && !resp_ready && !flush |=> resp_valid && $stable(resp);
	endproperty

	property resp_idle_in_reset;
		@(posedge clk) reset |=> !resp_valid;
	endproperty

	property no_accept_in_flush;
		@(posedge clk) flush |-> !req_ready;
	endproperty

	resp_held_a: assert property (resp_held) else begin
		$error("resp_valid dropped or resp changed before resp_ready");
		failures++;
	end

	resp_idle_in_reset_a: assert property (resp_idle_in_reset) else begin
		$error("resp_valid was high after a reset cycle");
		failures++;
	end

	no_accept_in_flush_a: assert property (no_accept_in_flush) else begin
		$error("req_ready was high during a flush");
		failures++;
	end

endmodule

// ==== bench/mul_unit_tb.sv ====
`timescale 1ns/1ps

module mul_unit_tb;

	localparam int TIMEOUT_CYCLES = 50;
	localparam int RANDOM_CYCLES = 2000;

	logic clk;
	logic reset;
	logic flush;
	logic req_valid;
	mul_pkg::mul_req_t req;
	logic req_ready;
	logic resp_valid;
	logic resp_ready;
	mul_pkg::mul_resp_t resp;

	int seed;
	mul_pkg::mul_resp_t exp_q[$]; // expected responses in request order.

	mul_unit mul_unit_i (
		.clk        (clk),
		.reset      (reset),
		.flush      (flush),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp       (resp)
	);

	bind mul_unit mul_unit_asserts asserts_i (
		.clk        (clk),
		.reset      (reset),
		.flush      (flush),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp       (resp)
	);

	always #20 clk = ~clk;

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("Error: %s = %h, expected %h", name, got, exp));
	endtask

	task automatic check_resp(input mul_pkg::mul_resp_t got, input mul_pkg::mul_resp_t exp);
		if (got.hi !== exp.hi)
			report_failure($sformatf("Error: resp.hi = %h, expected %h", got.hi, exp.hi));
		if (got.lo !== exp.lo)
			report_failure($sformatf("Error: resp.lo = %h, expected %h", got.lo, exp.lo));
	endtask

	// the low 128 bits of a product survive arithmetic modulo 2^128.
	function automatic mul_pkg::mul_resp_t reference_product(input mul_pkg::mul_req_t r);
		logic signed [127:0] a;
		logic signed [127:0] b;
		logic signed [127:0] p;
		mul_pkg::mul_resp_t out;

		if (r.mulw) begin
			a = $signed(r.multiplicand[31:0]);
			b = $signed(r.multiplier[31:0]);
		end else begin
			a = r.mode[0] ? $signed(r.multiplicand) : $signed({1'b0, r.multiplicand});
			b = r.mode[1] ? $signed(r.multiplier) : $signed({1'b0, r.multiplier});
		end
		p = a * b;
		out.hi = p[127:64];
		out.lo = p[63:0];
		return out;
	endfunction

	function automatic mul_pkg::dword_t pick_operand();
		case ($random(seed) & 7)
			0: return '0;
			1: return '1;
			2: return 64'h8000_0000_0000_0000;
			3: return {$random(seed), 32'h8000_0000}; // most negative word under random upper bits.
			default: return {$random(seed), $random(seed)};
		endcase
	endfunction

	function automatic mul_pkg::mul_req_t random_request();
		mul_pkg::mul_req_t r;

		r.multiplicand = pick_operand();
		r.multiplier = pick_operand();
		r.mode = mul_pkg::sign_mode_t'($random(seed));
		r.mulw = ($random(seed) & 3) == 0;
		return r;
	endfunction

	// scoreboard. A response taken at a flush edge is still checked before the queue clears.
	always @(posedge clk) begin
		if (!reset) begin
			if (resp_valid && resp_ready) begin
				if (exp_q.size() == 0)
					report_failure("a response came out with no request outstanding");
				else
					check_resp(resp, exp_q.pop_front());
			end
			if (flush)
				exp_q.delete();
			else if (req_valid && req_ready)
				exp_q.push_back(reference_product(req));
		end
	end

	// called at a falling edge with req_valid already high.
	task automatic wait_accept();
		int cycles;
		logic taken;

		cycles = 0;
		do begin
			@(posedge clk);
			taken = req_ready;
			cycles++;
		end while (!taken && cycles < TIMEOUT_CYCLES);
		if (!taken)
			report_failure("a request was not accepted within the timeout");
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic offer_request(input mul_pkg::mul_req_t r);
		@(negedge clk);
		req_valid = 1'b1;
		req = r;
		wait_accept();
	endtask

	task automatic wait_drained();
		int cycles;

		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while ((exp_q.size() != 0 || resp_valid) && cycles < TIMEOUT_CYCLES);
		if (exp_q.size() != 0 || resp_valid)
			report_failure("the pipeline did not drain within the timeout");
	endtask

	task automatic check_latency(input mul_pkg::mul_req_t r);
		int cycles;

		offer_request(r);
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!resp_valid && cycles < TIMEOUT_CYCLES);
		if (!resp_valid)
			report_failure("no response arrived for an accepted request");
		if (cycles != 2)
			report_failure($sformatf("response came %0d cycles after acceptance, not 2", cycles));
	endtask

	// leaves a refused request pending on the port.
	task automatic fill_until_stall();
		int accepted;
		logic taken;

		accepted = 0;
		do begin
			@(negedge clk);
			req_valid = 1'b1;
			req = random_request();
			resp_ready = 1'b0;
			@(posedge clk);
			taken = req_ready;
			if (taken)
				accepted++;
		end while (taken && accepted < TIMEOUT_CYCLES);
		if (taken)
			report_failure("req_ready did not fall while resp_ready was held low");
		if (accepted != 3)
			report_failure($sformatf("%0d requests accepted before req_ready fell, not 3", accepted));
	endtask

	task automatic random_traffic();
		logic taken;

		taken = 1'b0;
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			@(negedge clk);
			if (!req_valid || taken) begin // a refused request stays on the port unchanged.
				req_valid = ($random(seed) & 3) != 0;
				req = random_request();
			end
			resp_ready = ($random(seed) & 3) != 0;
			flush = ($random(seed) & 63) == 0;
			@(posedge clk);
			taken = req_valid && req_ready;
		end
		@(negedge clk);
		flush = 1'b0;
		resp_ready = 1'b1;
		if (req_valid && !taken)
			wait_accept();
		else
			req_valid = 1'b0;
	endtask

	initial begin
		mul_pkg::mul_req_t r;

		seed = 84008;
		clk = 1'b0;
		reset = 1'b1;
		flush = 1'b0;
		req_valid = 1'b0;
		req = '0;
		resp_ready = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_bit("resp_valid", resp_valid, 1'b0);
		check_bit("req_ready", req_ready, 1'b1);

		// every mode, doubleword and word.
		resp_ready = 1'b1;
		for (int m = 0; m < 8; m++) begin
			r = random_request();
			r.mode = m[1:0];
			r.mulw = m[2];
			check_latency(r);
		end
		wait_drained();

		fill_until_stall();
		@(negedge clk);
		resp_ready = 1'b1;
		wait_accept();
		wait_drained();

		// the pending request is refused during the flush and taken afterwards.
		resp_ready = 1'b0;
		offer_request(random_request());
		offer_request(random_request());
		req_valid = 1'b1; // the buffer still has room, only the flush refuses this one.
		req = random_request();
		flush = 1'b1;
		@(posedge clk);
		check_bit("req_ready", req_ready, 1'b0);
		@(negedge clk);
		flush = 1'b0;
		resp_ready = 1'b1;
		if (exp_q.size() != 0)
			report_failure("requests in flight were still expected after the flush");
		check_bit("resp_valid", resp_valid, 1'b0);
		wait_accept();
		wait_drained();

		random_traffic();
		wait_drained();

		if (exp_q.size() != 0 || mul_unit_i.asserts_i.failures != 0) begin
			report_failure($sformatf("%0d assertion failures and %0d missing responses",
				mul_unit_i.asserts_i.failures, exp_q.size()));
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

// ==== design/booth_pp_gen.sv ====
`timescale 1ns/1ps

module booth_pp_gen (
	input mul_pkg::mul_req_t req,
	output mul_pkg::pp_bundle_t pp
);

	mul_pkg::ext_operand_t a_ext;
	mul_pkg::ext_operand_t b_ext;
	logic [mul_pkg::EXT_W:0] a_grp;

	// word ops look only at the low half, sign extended whatever the mode says.
	function automatic mul_pkg::ext_operand_t extend(
		input mul_pkg::dword_t value,
		input logic is_signed,
		input logic word
	);
		if (word) begin
			return {{(mul_pkg::EXT_W - mul_pkg::WORD_W){value[mul_pkg::WORD_W-1]}},
				value[mul_pkg::WORD_W-1:0]};
		end
		return {{(mul_pkg::EXT_W - mul_pkg::DWORD_W){is_signed & value[mul_pkg::DWORD_W-1]}},
			value};
	endfunction

	assign a_ext = extend(req.multiplicand, req.mode[0], req.mulw);
	assign b_ext = extend(req.multiplier, req.mode[1], req.mulw);
	assign a_grp = {a_ext, 1'b0}; // the implicit zero below bit 0 starts the first group.

	always_comb begin
		mul_pkg::pp_row_t b_wide;
		mul_pkg::pp_row_t mag;
		logic [2:0] grp;
		logic neg_bit;

		b_wide = {{(mul_pkg::PP_WIDTH - mul_pkg::EXT_W){b_ext[mul_pkg::EXT_W-1]}}, b_ext};
		for (int i = 0; i < mul_pkg::NUM_PP; i++) begin
			grp = a_grp[2*i +: 3];
			case (grp)
				3'b001, 3'b010, 3'b101, 3'b110: mag = b_wide;
				3'b011, 3'b100: mag = b_wide << 1;
				default: mag = '0;
			endcase
			// 3'b111 is a zero digit and must not negate.
			neg_bit = grp[2] & ~(grp[1] & grp[0]);

			// inverting before the shift keeps zeros below the row, so the +1 lands at 2*i.
			pp.rows[i] = (neg_bit ? ~mag : mag) << (2 * i);
			pp.neg[i] = neg_bit;
		end
	end

endmodule

// ==== design/csa_tree.sv ====
`timescale 1ns/1ps

module csa_tree (
	input mul_pkg::pp_bundle_t bundle,
	output mul_pkg::pp_row_t sum,
	output mul_pkg::pp_row_t carry
);

	// number of rows left after the given number of 3:2 levels.
	function automatic int rows_at(input int level);
		int n;

		n = mul_pkg::NUM_PP + 1;
		for (int k = 0; k < level; k++) begin
			n = 2 * (n / 3) + n % 3;
		end
		return n;
	endfunction

	wire mul_pkg::pp_row_t row [0:mul_pkg::CSA_LEVELS][0:mul_pkg::NUM_PP];
	mul_pkg::pp_row_t neg_row;

	// the negate bits sit at even columns only, so they pack into one extra row.
	always_comb begin
		neg_row = '0;
		for (int i = 0; i < mul_pkg::NUM_PP; i++) begin
			neg_row[2*i] = bundle.neg[i];
		end
	end

	genvar r;
	genvar l;
	genvar g;
	generate
		for (r = 0; r < mul_pkg::NUM_PP; r++) begin : g_load
			assign row[0][r] = bundle.rows[r];
		end
		assign row[0][mul_pkg::NUM_PP] = neg_row;

		for (l = 0; l < mul_pkg::CSA_LEVELS; l++) begin : g_level
			for (g = 0; g < rows_at(l) / 3; g++) begin : g_csa
				mul_pkg::pp_row_t x;
				mul_pkg::pp_row_t y;
				mul_pkg::pp_row_t z;

				assign x = row[l][3*g];
				assign y = row[l][3*g+1];
				assign z = row[l][3*g+2];
				assign row[l+1][2*g] = x ^ y ^ z;
				// carries out of bit 131 fall away, the sum is kept modulo 2^132.
				assign row[l+1][2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
			end

			// rows that do not fill a group of three move down unchanged.
			for (g = 0; g < rows_at(l) % 3; g++) begin : g_pass
				assign row[l+1][2*(rows_at(l)/3)+g] = row[l][3*(rows_at(l)/3)+g];
			end
		end
	endgenerate

	assign sum = row[mul_pkg::CSA_LEVELS][0];
	assign carry = row[mul_pkg::CSA_LEVELS][1];

endmodule

// ==== design/mul_pkg.sv ====
package mul_pkg;

	localparam int DWORD_W = 64;
	localparam int WORD_W = 32;
	localparam int EXT_W = DWORD_W + 2; // two extra bits keep the sign of an unsigned operand.
	localparam int PP_WIDTH = 2 * EXT_W;
	localparam int NUM_PP = EXT_W / 2;
	// 34 rows (33 products plus the negate row) reach two rows after eight 3:2 levels.
	localparam int CSA_LEVELS = 8;

	typedef logic [DWORD_W-1:0] dword_t;
	typedef logic [EXT_W-1:0] ext_operand_t;
	typedef logic [PP_WIDTH-1:0] pp_row_t;
	typedef logic [1:0] sign_mode_t; // bit 0 is the multiplicand, bit 1 the multiplier.

	typedef struct packed {
		dword_t multiplicand;
		dword_t multiplier;
		sign_mode_t mode;
		logic mulw;
	} mul_req_t;

	typedef struct packed {
		pp_row_t [NUM_PP-1:0] rows;
		logic [NUM_PP-1:0] neg; // the +1 of each inverted row, at the row's first column.
	} pp_bundle_t;

	typedef struct packed {
		dword_t hi;
		dword_t lo;
	} mul_resp_t;

	typedef enum logic [1:0] {
		BUF_EMPTY,
		BUF_ONE,
		BUF_TWO
	} buf_state_t;

endpackage

// ==== design/mul_result_stage.sv ====
`timescale 1ns/1ps

module mul_result_stage (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic in_valid,
	output logic in_ready,
	input mul_pkg::pp_row_t sum,
	input mul_pkg::pp_row_t carry,
	output logic resp_valid,
	input logic resp_ready,
	output mul_pkg::mul_resp_t resp
);

	mul_pkg::pp_row_t product;

	assign product = sum + carry; // only the low 128 bits are kept.

	// the register takes a new item when it is empty or its item leaves this cycle.
	assign in_ready = !resp_valid || resp_ready;

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			resp_valid <= 1'b0;
		end else if (in_ready) begin
			resp_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			resp.hi <= product[2*mul_pkg::DWORD_W-1:mul_pkg::DWORD_W];
			resp.lo <= product[mul_pkg::DWORD_W-1:0];
		end
	end

endmodule

// ==== design/mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic req_valid,
	input mul_pkg::mul_req_t req,
	output logic req_ready,
	output logic resp_valid,
	input logic resp_ready,
	output mul_pkg::mul_resp_t resp
);

	mul_pkg::pp_bundle_t pp_bundle;
	logic buf_valid;
	logic buf_ready;
	mul_pkg::pp_bundle_t buf_bundle;
	mul_pkg::pp_row_t sum;
	mul_pkg::pp_row_t carry;

	// the generator is combinational, so the request handshake is the buffer's input side.
	booth_pp_gen booth_i (
		.req (req),
		.pp  (pp_bundle)
	);

	pp_skid_buffer buffer_i (
		.clk        (clk),
		.reset      (reset),
		.flush      (flush),
		.in_valid   (req_valid),
		.in_ready   (req_ready),
		.in_bundle  (pp_bundle),
		.out_valid  (buf_valid),
		.out_ready  (buf_ready),
		.out_bundle (buf_bundle)
	);

	csa_tree tree_i (
		.bundle (buf_bundle),
		.sum    (sum),
		.carry  (carry)
	);

	mul_result_stage result_i (
		.clk        (clk),
		.reset      (reset),
		.flush      (flush),
		.in_valid   (buf_valid),
		.in_ready   (buf_ready),
		.sum        (sum),
		.carry      (carry),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp       (resp)
	);

endmodule

// ==== design/pp_skid_buffer.sv ====
`timescale 1ns/1ps

module pp_skid_buffer (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic in_valid,
	output logic in_ready,
	input mul_pkg::pp_bundle_t in_bundle,
	output logic out_valid,
	input logic out_ready,
	output mul_pkg::pp_bundle_t out_bundle
);

	mul_pkg::buf_state_t state;
	mul_pkg::pp_bundle_t head;
	mul_pkg::pp_bundle_t tail;
	logic push;
	logic pop;

	// a flush cycle refuses new work so nothing slips in behind it.
	assign in_ready = (state != mul_pkg::BUF_TWO) && !flush;
	assign out_valid = (state != mul_pkg::BUF_EMPTY);
	assign out_bundle = head;

	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			state <= mul_pkg::BUF_EMPTY;
		end else begin
			case (state)
				mul_pkg::BUF_EMPTY: begin
					if (push) state <= mul_pkg::BUF_ONE;
				end
				mul_pkg::BUF_ONE: begin
					if (push && !pop) state <= mul_pkg::BUF_TWO;
					else if (pop && !push) state <= mul_pkg::BUF_EMPTY;
				end
				mul_pkg::BUF_TWO: begin
					if (pop) state <= mul_pkg::BUF_ONE; // no push here, in_ready is low.
				end
				default: state <= mul_pkg::BUF_EMPTY;
			endcase
		end
	end

	// the head slot always feeds the output. The tail only holds the second entry.
	always_ff @(posedge clk) begin
		if (state == mul_pkg::BUF_TWO) begin
			if (pop) head <= tail;
		end else if (push) begin
			if (state == mul_pkg::BUF_EMPTY || pop) head <= in_bundle;
			else tail <= in_bundle;
		end
	end

endmodule

// ==== mul_unit.f ====
design/mul_pkg.sv
design/booth_pp_gen.sv
design/pp_skid_buffer.sv
design/csa_tree.sv
design/mul_result_stage.sv
design/mul_unit.sv
bench/mul_unit_asserts.sv
bench/mul_unit_tb.sv
